// ==== logic/jtag_pkg.sv ====
// Shared TAP controller states, instruction codes and register widths for the JTAG network

package jtag_pkg;

    // ------------------------------------------------------------
    // Register widths
    // ------------------------------------------------------------

    // Instruction register length, the same for every TAP
    parameter int IR_WIDTH = 4;

    // IDCODE register length
    parameter int IDCODE_WIDTH = 32;

    // Version field in the top bits of each IDCODE
    parameter int VERCODE_WIDTH = 4;

    // Fixed pattern loaded in Capture-IR
    parameter logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001;

    // ------------------------------------------------------------
    // IEEE 1149.1 controller states
    // ------------------------------------------------------------

    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr_scan,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir_scan,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_t;

    // ------------------------------------------------------------
    // Instruction opcodes
    // ------------------------------------------------------------

    // Any code not listed here decodes as BYPASS
    typedef enum logic [IR_WIDTH-1:0] {
        IDCODE    = 4'b0001,
        TAPNW_SEL = 4'b0011,
        BYPASS    = 4'b1111
    } tap_instr_t;

endpackage

// ==== logic/tap_fsm.sv ====
// IEEE 1149.1 TAP controller state machine, instantiated once inside every TAP
`timescale 1ns/1ps

module tap_fsm (
    input  logic                 tck,
    input  logic                 rst_n,
    input  logic                 tms,
    output jtag_pkg::tap_state_t state
);

    jtag_pkg::tap_state_t state_d;

    // ------------------------------------------------------------
    // Next-state table, one step per tck edge
    // ------------------------------------------------------------

    always_comb begin
        state_d = state;
        case (state)
            jtag_pkg::test_logic_reset:
                state_d = tms ? jtag_pkg::test_logic_reset : jtag_pkg::run_test_idle;
            jtag_pkg::run_test_idle:
                state_d = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;

            // Data register column
            jtag_pkg::select_dr_scan:
                state_d = tms ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
            jtag_pkg::capture_dr:
                state_d = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::shift_dr:
                state_d = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::exit1_dr:
                state_d = tms ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
            jtag_pkg::pause_dr:
                state_d = tms ? jtag_pkg::exit2_dr : jtag_pkg::pause_dr;
            jtag_pkg::exit2_dr:
                state_d = tms ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
            jtag_pkg::update_dr:
                state_d = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;

            // Instruction register column
            jtag_pkg::select_ir_scan:
                state_d = tms ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;
            jtag_pkg::capture_ir:
                state_d = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::shift_ir:
                state_d = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::exit1_ir:
                state_d = tms ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
            jtag_pkg::pause_ir:
                state_d = tms ? jtag_pkg::exit2_ir : jtag_pkg::pause_ir;
            jtag_pkg::exit2_ir:
                state_d = tms ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
            jtag_pkg::update_ir:
                state_d = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            default:
                state_d = jtag_pkg::test_logic_reset;
        endcase
    end

    // State register
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            state <= jtag_pkg::test_logic_reset;
        end else begin
            state <= state_d;
        end
    end

endmodule

// ==== logic/mtap.sv ====
// Master TAP with IR, IDCODE, BYPASS and the select register that drives the TAP network
`timescale 1ns/1ps

module mtap #(
    parameter int NUM_STAPS = 2
) (
    input  logic                               tck,
    input  logic                               rst_n,
    input  logic                               tms,
    input  logic                               tdi,
    input  logic [jtag_pkg::VERCODE_WIDTH-1:0] vercode,
    input  logic [jtag_pkg::IDCODE_WIDTH-1:0]  idcode,
    output logic                               tdo,
    output logic                               tdo_en,
    output logic [NUM_STAPS-1:0]               enabletap
);

    jtag_pkg::tap_state_t            state;
    jtag_pkg::tap_instr_t            ir_q;
    logic [jtag_pkg::IR_WIDTH-1:0]   ir_sr;
    logic [jtag_pkg::IDCODE_WIDTH-1:0] idcode_sr;
    logic [NUM_STAPS-1:0]            sel_sr;
    logic                            bypass_q;
    logic                            sel_idcode;
    logic                            sel_tapnw;

    tap_fsm u_tap_fsm (
        .tck   (tck),
        .rst_n (rst_n),
        .tms   (tms),
        .state (state)
    );

    // Unlisted codes fall through to bypass
    always_comb begin
        sel_idcode = 1'b0;
        sel_tapnw  = 1'b0;
        case (ir_q)
            jtag_pkg::IDCODE:    sel_idcode = 1'b1;
            jtag_pkg::TAPNW_SEL: sel_tapnw  = 1'b1;
            default:             ;
        endcase
    end

    // ------------------------------------------------------------
    // Instruction register
    // ------------------------------------------------------------

    always_ff @(posedge tck) begin
        if (state == jtag_pkg::capture_ir) begin
            ir_sr <= jtag_pkg::IR_CAPTURE;
        end else if (state == jtag_pkg::shift_ir) begin
            ir_sr <= {tdi, ir_sr[jtag_pkg::IR_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (!rst_n || state == jtag_pkg::test_logic_reset) begin
            ir_q <= jtag_pkg::IDCODE;
        end else if (state == jtag_pkg::update_ir) begin
            ir_q <= jtag_pkg::tap_instr_t'(ir_sr);
        end
    end

    // ------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------

    always_ff @(posedge tck) begin
        if (state == jtag_pkg::capture_dr) begin
            bypass_q  <= 1'b0;
            // Version on top, bit 0 tied high as 1149.1 requires
            idcode_sr <= {vercode,
                          idcode[jtag_pkg::IDCODE_WIDTH-jtag_pkg::VERCODE_WIDTH-1:1],
                          1'b1};
            sel_sr    <= enabletap;
        end else if (state == jtag_pkg::shift_dr) begin
            bypass_q <= tdi;
            if (sel_idcode) begin
                idcode_sr <= {tdi, idcode_sr[jtag_pkg::IDCODE_WIDTH-1:1]};
            end
            if (sel_tapnw) begin
                // Shift toward bit 0, also right for a single slave
                sel_sr <= NUM_STAPS'({tdi, sel_sr} >> 1);
            end
        end
    end

    // Network select, cleared whenever the controller passes through reset
    always_ff @(posedge tck) begin
        if (!rst_n || state == jtag_pkg::test_logic_reset) begin
            enabletap <= '0;
        end else if (state == jtag_pkg::update_dr && sel_tapnw) begin
            enabletap <= sel_sr;
        end
    end

    // ------------------------------------------------------------
    // Serial output
    // ------------------------------------------------------------

    always_comb begin
        tdo = 1'b0;
        if (state == jtag_pkg::shift_ir) begin
            tdo = ir_sr[0];
        end else if (state == jtag_pkg::shift_dr) begin
            if (sel_idcode) begin
                tdo = idcode_sr[0];
            end else if (sel_tapnw) begin
                tdo = sel_sr[0];
            end else begin
                tdo = bypass_q;
            end
        end
    end

    // All chain members shift together, so this enable covers the chain
    assign tdo_en = (state == jtag_pkg::shift_ir) || (state == jtag_pkg::shift_dr);

endmodule

// ==== logic/stap.sv ====
// Slave TAP with IR, IDCODE and BYPASS, linked into the scan chain by the TAP network
`timescale 1ns/1ps

module stap (
    input  logic                               tck,
    input  logic                               rst_n,
    input  logic                               tms,
    input  logic                               tdi,
    input  logic [jtag_pkg::VERCODE_WIDTH-1:0] vercode,
    input  logic [jtag_pkg::IDCODE_WIDTH-1:0]  idcode,
    output logic                               tdo
);

    jtag_pkg::tap_state_t              state;
    jtag_pkg::tap_instr_t              ir_q;
    logic [jtag_pkg::IR_WIDTH-1:0]     ir_sr;
    logic [jtag_pkg::IDCODE_WIDTH-1:0] idcode_sr;
    logic                              bypass_q;
    logic                              sel_idcode;

    tap_fsm u_tap_fsm (
        .tck   (tck),
        .rst_n (rst_n),
        .tms   (tms),
        .state (state)
    );

    // Only IDCODE has its own register here, TAPNW_SEL falls into bypass
    assign sel_idcode = (ir_q == jtag_pkg::IDCODE);

    // ------------------------------------------------------------
    // Instruction register
    // ------------------------------------------------------------

    always_ff @(posedge tck) begin
        if (state == jtag_pkg::capture_ir) begin
            ir_sr <= jtag_pkg::IR_CAPTURE;
        end else if (state == jtag_pkg::shift_ir) begin
            ir_sr <= {tdi, ir_sr[jtag_pkg::IR_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (!rst_n || state == jtag_pkg::test_logic_reset) begin
            ir_q <= jtag_pkg::IDCODE;
        end else if (state == jtag_pkg::update_ir) begin
            ir_q <= jtag_pkg::tap_instr_t'(ir_sr);
        end
    end

    // ------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------

    always_ff @(posedge tck) begin
        if (state == jtag_pkg::capture_dr) begin
            bypass_q  <= 1'b0;
            idcode_sr <= {vercode,
                          idcode[jtag_pkg::IDCODE_WIDTH-jtag_pkg::VERCODE_WIDTH-1:1],
                          1'b1};
        end else if (state == jtag_pkg::shift_dr) begin
            bypass_q <= tdi;
            if (sel_idcode) begin
                idcode_sr <= {tdi, idcode_sr[jtag_pkg::IDCODE_WIDTH-1:1]};
            end
        end
    end

    // Selected register LSB while shifting
    always_comb begin
        tdo = 1'b0;
        if (state == jtag_pkg::shift_ir) begin
            tdo = ir_sr[0];
        end else if (state == jtag_pkg::shift_dr) begin
            tdo = sel_idcode ? idcode_sr[0] : bypass_q;
        end
    end

endmodule

// ==== logic/tapnw.sv ====
// TAP network that gates slave TMS and threads serial data through the enabled slave TAPs
`timescale 1ns/1ps

module tapnw #(
    parameter int NUM_STAPS = 2
) (
    input  logic                 tms,
    input  logic [NUM_STAPS-1:0] enabletap,
    input  logic                 mtap_tdo,
    input  logic [NUM_STAPS-1:0] stap_tdo,
    output logic [NUM_STAPS-1:0] stap_tms,
    output logic [NUM_STAPS-1:0] stap_tdi,
    output logic                 tdo
);

    // ------------------------------------------------------------
    // Serial chain
    // ------------------------------------------------------------

    // Tap point after each member, index 0 is the master output
    logic [NUM_STAPS:0] chain;

    assign chain[0] = mtap_tdo;

    for (genvar i = 0; i < NUM_STAPS; i++) begin : g_link
        // Disabled slave parks in Run-Test/Idle with TMS low
        assign stap_tms[i] = tms & enabletap[i];

        // Each slave listens to the last enabled member ahead of it
        assign stap_tdi[i] = chain[i];

        // Skip the slave when it is not part of the chain
        assign chain[i+1] = enabletap[i] ? stap_tdo[i] : chain[i];
    end

    // Last enabled member, or the master alone
    assign tdo = chain[NUM_STAPS];

endmodule

// ==== logic/mtap_tapnw_top.sv ====
// Top level of the JTAG network joining the master TAP, the TAP network and the slave TAPs
`timescale 1ns/1ps

module mtap_tapnw_top #(
    parameter int NUM_STAPS = 2
) (
    input  logic                                              tck,
    input  logic                                              rst_n,
    input  logic                                              tms,
    input  logic                                              tdi,
    input  logic [jtag_pkg::VERCODE_WIDTH-1:0]                vercode,
    input  logic [jtag_pkg::IDCODE_WIDTH-1:0]                 idcode_mtap,
    input  logic [NUM_STAPS-1:0][jtag_pkg::IDCODE_WIDTH-1:0]  idcode_stap,
    output logic                                              tdo,
    output logic                                              tdo_en,
    output logic [NUM_STAPS-1:0]                              enabletap
);

    logic                 mtap_tdo;
    logic [NUM_STAPS-1:0] stap_tms;
    logic [NUM_STAPS-1:0] stap_tdi;
    logic [NUM_STAPS-1:0] stap_tdo;

    mtap #(
        .NUM_STAPS (NUM_STAPS)
    ) u_mtap (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .tdi       (tdi),
        .vercode   (vercode),
        .idcode    (idcode_mtap),
        .tdo       (mtap_tdo),
        .tdo_en    (tdo_en),
        .enabletap (enabletap)
    );

    tapnw #(
        .NUM_STAPS (NUM_STAPS)
    ) u_tapnw (
        .tms       (tms),
        .enabletap (enabletap),
        .mtap_tdo  (mtap_tdo),
        .stap_tdo  (stap_tdo),
        .stap_tms  (stap_tms),
        .stap_tdi  (stap_tdi),
        .tdo       (tdo)
    );

    // ------------------------------------------------------------
    // Slave TAPs
    // ------------------------------------------------------------

    for (genvar i = 0; i < NUM_STAPS; i++) begin : g_stap
        stap u_stap (
            .tck     (tck),
            .rst_n   (rst_n),
            .tms     (stap_tms[i]),
            .tdi     (stap_tdi[i]),
            .vercode (vercode),
            .idcode  (idcode_stap[i]),
            .tdo     (stap_tdo[i])
        );
    end

endmodule

// ==== test/mtap_tapnw_sva.sv ====
// Assertions on the master TAP state and its TDO enable, attached to mtap with bind
`timescale 1ns/1ps

module mtap_tapnw_sva (
    input logic                 tck,
    input logic                 rst_n,
    input logic                 tms,
    input logic                 tdo_en,
    input jtag_pkg::tap_state_t state
);

    int fail_count = 0;

    // Shift states are entered and held only with TMS low from Capture, Shift or Exit2
    tdo_en_shift: assert property (@(posedge tck) disable iff (!rst_n)
        tdo_en == ($past(rst_n) && !$past(tms) &&
                   ($past(state) inside {jtag_pkg::capture_dr, jtag_pkg::shift_dr,
                                         jtag_pkg::exit2_dr, jtag_pkg::capture_ir,
                                         jtag_pkg::shift_ir, jtag_pkg::exit2_ir})))
        else begin
            fail_count++;
            $error("tdo_en does not match the controller shift states");
        end

    // Five TMS-high edges reach Test-Logic-Reset from any state
    tms_reset_walk: assert property (@(posedge tck) disable iff (!rst_n)
        ($past(tms, 1) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4) && $past(tms, 5))
        |-> state == jtag_pkg::test_logic_reset)
        else begin
            fail_count++;
            $error("Controller not in Test-Logic-Reset after five TMS-high edges");
        end

endmodule

bind mtap mtap_tapnw_sva u_mtap_tapnw_sva (
    .tck    (tck),
    .rst_n  (rst_n),
    .tms    (tms),
    .tdo_en (tdo_en),
    .state  (state)
);

// ==== test/tb_mtap_tapnw.sv ====
// Testbench that replays the scans of the stim file through the JTAG network and checks the results
`timescale 1ns/1ps

module tb_mtap_tapnw;

    localparam int    NUM_STAPS = 2;
    localparam int    MAX_BITS  = 128;
    localparam string STIM_FILE = "test/mtap_tapnw_stim.txt";

    logic                                             tck;
    logic                                             rst_n;
    logic                                             tms;
    logic                                             tdi;
    logic [jtag_pkg::VERCODE_WIDTH-1:0]               vercode;
    logic [jtag_pkg::IDCODE_WIDTH-1:0]                idcode_mtap;
    logic [NUM_STAPS-1:0][jtag_pkg::IDCODE_WIDTH-1:0] idcode_stap;
    logic                                             tdo;
    logic                                             tdo_en;
    logic [NUM_STAPS-1:0]                             enabletap;

    // One entry per stim line
    string                name_q[$];
    string                kind_q[$];
    int                   len_q[$];
    logic [MAX_BITS-1:0]  tdi_q[$];
    logic [MAX_BITS-1:0]  tdo_q[$];
    logic [NUM_STAPS-1:0] en_q[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    mtap_tapnw_top #(
        .NUM_STAPS (NUM_STAPS)
    ) u_mtap_tapnw_top (
        .tck         (tck),
        .rst_n       (rst_n),
        .tms         (tms),
        .tdi         (tdi),
        .vercode     (vercode),
        .idcode_mtap (idcode_mtap),
        .idcode_stap (idcode_stap),
        .tdo         (tdo),
        .tdo_en      (tdo_en),
        .enabletap   (enabletap)
    );

    initial begin
        tck = 1'b0;
        forever #4 tck = ~tck;
    end

    always @(posedge tck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: scans still running after %0d tck cycles", cycle_count);
            stop_on_error();
        end
    end

    always @(negedge tck) begin
        if (u_mtap_tapnw_top.u_mtap.u_mtap_tapnw_sva.fail_count != 0) begin
            $display("A bound assertion on the master TAP failed");
            stop_on_error();
        end
    end

    // ------------------------------------------------------------
    // Scan and compare tasks
    // ------------------------------------------------------------

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "Stopped at first error");
    endtask

    // DUT acts on these values at the following edge
    task automatic drive_tap(input logic tms_val, input logic tdi_val);
        @(posedge tck);
        tms <= tms_val;
        tdi <= tdi_val;
    endtask

    task automatic check_tdo_en(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s tdo_en expected %b actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    // From Run-Test/Idle through one IR or DR scan and back, LSB first
    task automatic scan(input string name, input logic is_ir, input int len,
                        input logic [MAX_BITS-1:0] data_in,
                        output logic [MAX_BITS-1:0] data_out);
        data_out = '0;
        drive_tap(1'b1, 1'b0);
        if (is_ir) begin
            drive_tap(1'b1, 1'b0);
        end
        drive_tap(1'b0, 1'b0);
        drive_tap(1'b0, 1'b0);
        for (int i = 0; i < len; i++) begin
            drive_tap(i == len - 1, data_in[i]);
            @(negedge tck);
            data_out[i] = tdo;
            check_tdo_en(name, 1'b1, tdo_en);
        end
        // Exit1 to Update then back to idle
        drive_tap(1'b1, 1'b0);
        drive_tap(1'b0, 1'b0);
    endtask

    task automatic walk_to_reset();
        repeat (5) drive_tap(1'b1, 1'b0);
        drive_tap(1'b0, 1'b0);
    endtask

    task automatic compare_chain(input string name, input logic [MAX_BITS-1:0] expected,
                                 input logic [MAX_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s chain data expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic match_enable(input string name, input logic [NUM_STAPS-1:0] expected,
                                input logic [NUM_STAPS-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s enabletap expected %b actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        int                   fd;
        int                   total;
        int                   len;
        string                line;
        string                name;
        string                kind;
        logic [MAX_BITS-1:0]  tdi_data;
        logic [MAX_BITS-1:0]  tdo_exp;
        logic [MAX_BITS-1:0]  tdo_got;
        logic [NUM_STAPS-1:0] en_exp;

        rst_n          = 1'b0;
        tms            = 1'b0;
        tdi            = 1'b0;
        vercode        = 4'hA;
        idcode_mtap    = 32'h5123_4567;
        idcode_stap[0] = 32'h089A_BCDF;
        idcode_stap[1] = 32'h0FED_CBA8;
        total          = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            stop_on_error();
        end
        // Comment lines fail the scan and are skipped
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s %s %d %h %h %h", name, kind, len,
                        tdi_data, tdo_exp, en_exp) == 6) begin
                name_q.push_back(name);
                kind_q.push_back(kind);
                len_q.push_back(len);
                tdi_q.push_back(tdi_data);
                tdo_q.push_back(tdo_exp);
                en_q.push_back(en_exp);
                total += len + 6;
            end
        end
        $fclose(fd);
        if (name_q.size() == 0) begin
            $display("The stimulus file holds no scan operations");
            stop_on_error();
        end
        cycle_limit = total + 100;

        repeat (2) @(posedge tck);
        rst_n <= 1'b1;

        foreach (name_q[k]) begin
            tdo_got = '0;
            if (kind_q[k] == "TLR") begin
                walk_to_reset();
            end else begin
                scan(name_q[k], kind_q[k] == "IR", len_q[k], tdi_q[k], tdo_got);
            end
            // Update takes effect on this edge
            @(posedge tck);
            @(negedge tck);
            compare_chain(name_q[k], tdo_q[k], tdo_got);
            match_enable(name_q[k], en_q[k], enabletap);
            check_tdo_en(name_q[k], 1'b0, tdo_en);
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== test/mtap_tapnw_stim.txt ====
# name  op(IR DR TLR)  len  tdi_hex  tdo_hex(bit 0 out first)  enabletap_hex
# TLR walks TMS high five times and ignores len tdi and tdo
idcode_reset       DR   32   00000000   A1234567                   0
ir_master_sel      IR   4    3          1                          0
sel_both           DR   2    3          0                          3
ir_three_idcode    IR   12   111        111                        3
idcode_three       DR   96   0          A1234567A89ABCDFAFEDCBA9   3
ir_three_bypass    IR   12   FFF        111                        3
bypass_delay       DR   16   B5E3       AF18                       3
ir_three_sel       IR   12   333        111                        3
sel_stap1          DR   4    8          C                          2
ir_two_idcode      IR   8    11         11                         2
idcode_two         DR   64   0          A1234567AFEDCBA9           2
tlr_walk           TLR  0    0          0                          0
ir_master_only     IR   4    1          1                          0
idcode_after_tlr   DR   32   0          A1234567                   0

// ==== mtap_tapnw.f ====
logic/jtag_pkg.sv
logic/tap_fsm.sv
logic/mtap.sv
logic/stap.sv
logic/tapnw.sv
logic/mtap_tapnw_top.sv
test/mtap_tapnw_sva.sv
test/tb_mtap_tapnw.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mtap_tapnw
FILELIST  ?= mtap_tapnw.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
